/* Makefile */
# Verilator build and run of the housekeeping core testbench

TOP := tb_cl_scrub_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f cl_scrub_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cl_scrub_top.f */
verilog/cl_scrub_pkg.sv
verilog/scrb_if.sv
verilog/lib_pipe.sv
verilog/ddr_scrubber.sv
verilog/cl_shell_regs.sv
verilog/cl_scrub_top.sv
sim/tb_cl_scrub_top.sv

/* sim/tb_cl_scrub_top.sv */
// Directed testbench for the housekeeping core.
// A memory responder model acknowledges every scrub burst after a random delay
// and records the acknowledged addresses per channel.
// Each test is a task, and the run ends with a count of tests and errors.

`timescale 1ns/1ps

module tb_cl_scrub_top;

   localparam int NUM_DDR   = cl_scrub_pkg::NUM_DDR;
   localparam int BURSTS    = 8;    // 8 KiB per channel in 1 KiB bursts
   localparam int REC_DEPTH = 32;
   // Two scrub runs of up to 6 cycles per burst, plus reset and the short tests
   localparam int TEST_CYCLES    = 16 + 2 * (BURSTS * 6 + 20) + 120;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic                       clk = 1'b0;
   logic                       sync_rst_n;
   logic                       sh_cl_flr_assert;
   logic                       cl_sh_flr_done;
   cl_scrub_pkg::ctl_word_t    sh_cl_ctl0;
   cl_scrub_pkg::ready_vec_t   sh_cl_ddr_is_ready;
   cl_scrub_pkg::status_word_t cl_sh_status0;
   cl_scrub_pkg::status_word_t cl_sh_status1;
   cl_scrub_pkg::id_word_t     cl_sh_id0;
   cl_scrub_pkg::id_word_t     cl_sh_id1;
   logic [NUM_DDR-1:0]         scrb_req;
   cl_scrub_pkg::addr_t        scrb_addr [NUM_DDR];
   logic [NUM_DDR-1:0]         scrb_ack = '0;

   // Responder state and record of acknowledged bursts
   int                  ack_wait [NUM_DDR] = '{default: 0};
   int                  acked_cnt [NUM_DDR] = '{default: 0};
   cl_scrub_pkg::addr_t acked_addr [NUM_DDR][REC_DEPTH];

   logic [NUM_DDR-1:0] done_mask;
   int                 cycle_cnt = 0;
   int                 err_cnt;
   int                 test_cnt;
   int                 fail_cnt;

   cl_scrub_top u_cl_scrub_top (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .cl_sh_status0      (cl_sh_status0),
      .cl_sh_status1      (cl_sh_status1),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1),
      .scrb_req           (scrb_req),
      .scrb_addr          (scrb_addr),
      .scrb_ack           (scrb_ack)
   );

   always #10 clk = ~clk;

   //------------------------------------------------------------
   // Memory responder
   //------------------------------------------------------------

   // One ack pulse 1 to 4 cycles after each request
   initial
   begin
      void'($urandom(32'h68a57fda));
      forever
      begin
         @(negedge clk);
         for (int c = 0; c < NUM_DDR; c++)
         begin
            if (scrb_ack[c] || !scrb_req[c])
            begin
               scrb_ack[c] = 1'b0;
               ack_wait[c] = 0;
            end
            else if (ack_wait[c] == 0)
            begin
               ack_wait[c] = 1 + ($urandom % 4);
            end
            else if (ack_wait[c] == 1)
            begin
               scrb_ack[c] = 1'b1;
               ack_wait[c] = 0;
               if (acked_cnt[c] < REC_DEPTH)
               begin
                  acked_addr[c][acked_cnt[c]] = scrb_addr[c];
               end
               acked_cnt[c] = acked_cnt[c] + 1;
            end
            else
            begin
               ack_wait[c] = ack_wait[c] - 1;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   //------------------------------------------------------------
   // Compare tasks and helpers
   //------------------------------------------------------------

   task automatic check_status(input string name, input cl_scrub_pkg::status_word_t got,
                               input cl_scrub_pkg::status_word_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_id(input string name, input cl_scrub_pkg::id_word_t got,
                           input cl_scrub_pkg::id_word_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input cl_scrub_pkg::addr_t got,
                             input cl_scrub_pkg::addr_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_pulses(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      test_cnt++;
      if (err_cnt == err_before)
      begin
         $display("%s: ok", name);
      end
      else
      begin
         fail_cnt++;
         $display("%s: FAILED with %0d errors", name, err_cnt - err_before);
      end
   endtask

   // Idle channels hold address zero and finished ones keep their last burst
   function automatic cl_scrub_pkg::addr_t last_req_addr(input int c);
      if (!done_mask[c])
      begin
         return '0;
      end
      return cl_scrub_pkg::addr_t'(BURSTS - 1) * cl_scrub_pkg::SCRB_BURST_BYTES;
   endfunction

   function automatic cl_scrub_pkg::status_word_t expected_status0(input logic dbg);
      cl_scrub_pkg::status_word_t exp;
      cl_scrub_pkg::scrb_state_t  st;
      exp = '0;
      if (dbg)
      begin
         for (int c = 0; c < NUM_DDR; c++)
         begin
            st = done_mask[c] ? cl_scrub_pkg::SCRB_DONE : cl_scrub_pkg::SCRB_IDLE;
            exp[16+4*c +: 4] = {1'b0, st};
         end
      end
      else
      begin
         exp[31:12] = cl_scrub_pkg::STATUS_SIGNATURE;
      end
      exp[11:8] = 4'hf;
      exp[7:4]  = done_mask;
      exp[3:0]  = sh_cl_ddr_is_ready;
      return exp;
   endfunction

   // Step the debug select through all eight values and read the ID words
   task automatic sweep_debug_select(input logic [NUM_DDR-1:0] enables);
      int                  chan;
      cl_scrub_pkg::addr_t exp_addr;
      for (int s = 0; s < 8; s++)
      begin
         sh_cl_ctl0 = {1'b1, 3'(s), 24'h0, enables};
         repeat (3) @(negedge clk);
         chan     = (s < NUM_DDR) ? s : 0;
         exp_addr = last_req_addr(chan);
         check_id($sformatf("cl_sh_id0 select %0d", s), cl_sh_id0, exp_addr[31:0]);
         check_id($sformatf("cl_sh_id1 select %0d", s), cl_sh_id1, exp_addr[63:32]);
      end
   endtask

   // Enable the channels in ctl and wait for their done bits
   task automatic run_scrub(input cl_scrub_pkg::ctl_word_t ctl);
      int                 start [NUM_DDR];
      logic [NUM_DDR-1:0] active;
      logic [NUM_DDR-1:0] stray_req;
      logic [NUM_DDR-1:0] stray_done;
      active     = ctl[NUM_DDR-1:0] & sh_cl_ddr_is_ready;
      stray_req  = '0;
      stray_done = '0;
      for (int c = 0; c < NUM_DDR; c++)
      begin
         start[c] = acked_cnt[c];
      end
      sh_cl_ctl0 = ctl;
      do
      begin
         @(negedge clk);
         stray_req  = stray_req | (scrb_req & ~active);
         stray_done = stray_done | (cl_sh_status0[7:4] & ~active);
      end while (cl_sh_status0[7:4] !== active);
      // Finished channels must stay quiet
      repeat (8)
      begin
         @(negedge clk);
         stray_req = stray_req | scrb_req;
      end
      if (stray_req != '0 || stray_done != '0)
      begin
         $display("Unexpected request %b or done bit %b on an inactive or finished channel",
                  stray_req, stray_done);
         err_cnt++;
      end
      done_mask = active;
      for (int c = 0; c < NUM_DDR; c++)
      begin
         if (acked_cnt[c] - start[c] != (active[c] ? BURSTS : 0))
         begin
            $display("Channel %0d completed %0d bursts instead of %0d", c,
                     acked_cnt[c] - start[c], active[c] ? BURSTS : 0);
            err_cnt++;
         end
         else if (active[c])
         begin
            for (int k = 0; k < BURSTS; k++)
            begin
               check_addr($sformatf("acked_addr[%0d][%0d]", c, k), acked_addr[c][start[c]+k],
                          cl_scrub_pkg::addr_t'(k) * cl_scrub_pkg::SCRB_BURST_BYTES);
            end
         end
      end
      check_status("cl_sh_status0", cl_sh_status0, expected_status0(1'b0));
   endtask

   //------------------------------------------------------------
   // Tests
   //------------------------------------------------------------

   task automatic test_reset();
      int err_before;
      err_before = err_cnt;
      repeat (4) @(negedge clk);
      check_status("cl_sh_status0", cl_sh_status0, expected_status0(1'b0));
      check_status("cl_sh_status1", cl_sh_status1, cl_scrub_pkg::CL_VERSION);
      check_id("cl_sh_id0", cl_sh_id0, cl_scrub_pkg::CL_SH_ID0);
      check_id("cl_sh_id1", cl_sh_id1, cl_scrub_pkg::CL_SH_ID1);
      if (scrb_req != '0)
      begin
         $display("Burst request %b raised while every channel is disabled", scrb_req);
         err_cnt++;
      end
      finish_test("reset values", err_before);
   endtask

   task automatic test_scrub_all();
      int err_before;
      err_before = err_cnt;
      run_scrub(32'h0000_000f);
      finish_test("scrub all channels", err_before);
   endtask

   task automatic test_partial();
      int err_before;
      err_before = err_cnt;
      // Channel 2 loses ready before anything is enabled again
      sh_cl_ctl0         = '0;
      sh_cl_ddr_is_ready = 4'b1011;
      repeat (6) @(negedge clk);
      done_mask = '0;
      run_scrub(32'h0000_0007);
      finish_test("idle channels stay quiet", err_before);
   endtask

   task automatic test_debug();
      int err_before;
      err_before = err_cnt;
      sweep_debug_select(4'b0111);
      check_status("cl_sh_status0", cl_sh_status0, expected_status0(1'b1));
      finish_test("debug readout", err_before);
   endtask

   task automatic test_disable();
      int err_before;
      err_before = err_cnt;
      sh_cl_ctl0   = {1'b1, 3'd0, 24'h0, 4'b0110};
      done_mask[0] = 1'b0;
      repeat (3) @(negedge clk);
      check_status("cl_sh_status0", cl_sh_status0, expected_status0(1'b1));
      check_addr("scrb_addr[0]", scrb_addr[0], '0);
      // Channel 0 now reads zero while channel 1 still shows its last burst
      sweep_debug_select(4'b0110);
      finish_test("disable after done", err_before);
   endtask

   // Bit k of the pattern is the done output k cycles after the first drive
   task automatic flr_pulses(input int len, input logic [15:0] exp);
      logic [15:0] seen;
      seen = '0;
      for (int k = 0; k < 16; k++)
      begin
         @(negedge clk);
         seen[k]          = cl_sh_flr_done;
         sh_cl_flr_assert = (k < len);
      end
      check_pulses($sformatf("cl_sh_flr_done after %0d-cycle assert", len), seen, exp);
   endtask

   task automatic test_flr();
      int err_before;
      err_before = err_cnt;
      flr_pulses(1, 16'h0004);
      flr_pulses(6, 16'h0054);
      finish_test("function-level reset", err_before);
   endtask

   initial
   begin
      sync_rst_n         = 1'b0;
      sh_cl_flr_assert   = 1'b0;
      sh_cl_ctl0         = '0;
      sh_cl_ddr_is_ready = 4'hf;
      done_mask          = '0;
      err_cnt            = 0;
      test_cnt           = 0;
      fail_cnt           = 0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;

      test_reset();
      test_scrub_all();
      test_partial();
      test_debug();
      test_disable();
      test_flr();

      $display("Tests run %0d, tests failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* verilog/cl_scrub_pkg.sv */
// Shared sizes, scrubber constants, shell word types and ID constants
// for the custom-logic housekeeping core.
// Every design file refers to these by scoped name, never by import.

package cl_scrub_pkg;

   //------------------------------------------------------------
   // Sizes
   //------------------------------------------------------------

   localparam int NUM_DDR = 4;
   localparam int ADDR_W  = 64;

   typedef logic [ADDR_W-1:0] addr_t;

   //------------------------------------------------------------
   // Scrubber constants
   //------------------------------------------------------------

   // Only 8 KiB per channel is walked in simulation
   // Hardware builds use 64'h3_FFFF_FFFF (16 GiB)
   localparam addr_t SCRB_MAX_ADDR = 64'h0000_0000_0000_1fff;

   localparam int SCRB_BURST_LEN_MINUS1 = 15;
   localparam int SCRB_BEAT_BYTES       = 64;

   // One full burst of 64-byte beats
   localparam addr_t SCRB_BURST_BYTES =
      addr_t'((SCRB_BURST_LEN_MINUS1 + 1) * SCRB_BEAT_BYTES);

   typedef enum logic [2:0] {
      SCRB_IDLE = 3'd0,
      SCRB_RUN  = 3'd1,
      SCRB_DONE = 3'd2
   } scrb_state_t;

   //------------------------------------------------------------
   // Shell words
   //------------------------------------------------------------

   typedef logic [31:0]        ctl_word_t;
   typedef logic [31:0]        status_word_t;
   typedef logic [31:0]        id_word_t;
   typedef logic [NUM_DDR-1:0] ready_vec_t;

   // Control word layout
   // Bits NUM_DDR-1:0 are the per-channel scrub enables
   localparam int CTL_DBG_EN_BIT  = 31;
   localparam int CTL_DBG_SEL_LSB = 28;
   localparam int CTL_DBG_SEL_W   = 3;

   // Register stages on the shell inputs
   localparam int CTL_STAGES   = 1;
   localparam int READY_STAGES = 2;

   //------------------------------------------------------------
   // Status and ID constants
   //------------------------------------------------------------

   // Fills status0[31:12] while debug is off
   localparam logic [19:0] STATUS_SIGNATURE = 20'ha1111;

   localparam status_word_t CL_VERSION = 32'hee_ee_ee_00;

   // Device and subsystem IDs
   localparam id_word_t CL_SH_ID0 = 32'hf00c_1d0e;
   localparam id_word_t CL_SH_ID1 = 32'h1d52_fe0c;

endpackage

/* verilog/cl_scrub_top.sv */
// Top level of the housekeeping core.
// Registers the shell control word and DDR ready vector, then feeds the
// register block and one scrubber per DDR channel.
// Each channel's burst request, address and acknowledge are plain ports.

`timescale 1ns/1ps

module cl_scrub_top (
   input  logic                       clk,
   input  logic                       sync_rst_n,

   input  logic                       sh_cl_flr_assert,
   output logic                       cl_sh_flr_done,

   input  cl_scrub_pkg::ctl_word_t    sh_cl_ctl0,
   input  cl_scrub_pkg::ready_vec_t   sh_cl_ddr_is_ready,

   output cl_scrub_pkg::status_word_t cl_sh_status0,
   output cl_scrub_pkg::status_word_t cl_sh_status1,
   output cl_scrub_pkg::id_word_t     cl_sh_id0,
   output cl_scrub_pkg::id_word_t     cl_sh_id1,

   output logic [cl_scrub_pkg::NUM_DDR-1:0] scrb_req,
   output cl_scrub_pkg::addr_t              scrb_addr [cl_scrub_pkg::NUM_DDR],
   input  logic [cl_scrub_pkg::NUM_DDR-1:0] scrb_ack
);

   cl_scrub_pkg::ctl_word_t  ctl_q;
   cl_scrub_pkg::ready_vec_t ready_q;

   scrb_if scrb_bus [cl_scrub_pkg::NUM_DDR] ();

   //------------------------------------------------------------
   // Input pipelines
   //------------------------------------------------------------

   lib_pipe #(
      .T      (cl_scrub_pkg::ctl_word_t),
      .STAGES (cl_scrub_pkg::CTL_STAGES)
   ) u_ctl_pipe (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_bus     (sh_cl_ctl0),
      .out_bus    (ctl_q)
   );

   lib_pipe #(
      .T      (cl_scrub_pkg::ready_vec_t),
      .STAGES (cl_scrub_pkg::READY_STAGES)
   ) u_ready_pipe (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_bus     (sh_cl_ddr_is_ready),
      .out_bus    (ready_q)
   );

   //------------------------------------------------------------
   // Register block and scrubbers
   //------------------------------------------------------------

   cl_shell_regs u_cl_shell_regs (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl_q      (ctl_q),
      .ready_q    (ready_q),
      .scrb       (scrb_bus),
      .flr_assert (sh_cl_flr_assert),
      .flr_done   (cl_sh_flr_done),
      .status0    (cl_sh_status0),
      .status1    (cl_sh_status1),
      .id0        (cl_sh_id0),
      .id1        (cl_sh_id1)
   );

   for (genvar i = 0; i < cl_scrub_pkg::NUM_DDR; i++)
   begin : g_scrb
      ddr_scrubber u_ddr_scrubber (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .ddr_ready  (ready_q[i]),
         .scrb       (scrb_bus[i]),
         .scrb_req   (scrb_req[i]),
         .scrb_addr  (scrb_addr[i]),
         .scrb_ack   (scrb_ack[i])
      );
   end

endmodule

/* verilog/cl_shell_regs.sv */
// Shell-facing register block.
// Decodes the control word into scrub enables and the debug select,
// builds the registered status and ID words, and answers the
// function-level reset request with a done pulse.

`timescale 1ns/1ps

module cl_shell_regs (
   input  logic                       clk,
   input  logic                       sync_rst_n,
   input  cl_scrub_pkg::ctl_word_t    ctl_q,
   input  cl_scrub_pkg::ready_vec_t   ready_q,
   scrb_if.ctl                        scrb [cl_scrub_pkg::NUM_DDR],
   input  logic                       flr_assert,
   output logic                       flr_done,
   output cl_scrub_pkg::status_word_t status0,
   output cl_scrub_pkg::status_word_t status1,
   output cl_scrub_pkg::id_word_t     id0,
   output cl_scrub_pkg::id_word_t     id1
);

   logic                                     dbg_en;
   logic [cl_scrub_pkg::CTL_DBG_SEL_W-1:0]   dbg_sel;
   logic [$clog2(cl_scrub_pkg::NUM_DDR)-1:0] dbg_chan;
   logic [cl_scrub_pkg::NUM_DDR-1:0]         done_vec;
   logic [4*cl_scrub_pkg::NUM_DDR-1:0]       dbg_states;
   cl_scrub_pkg::addr_t                      chan_addr [cl_scrub_pkg::NUM_DDR];
   cl_scrub_pkg::addr_t                      dbg_addr;
   logic                                     flr_assert_q;

   //------------------------------------------------------------
   // Control decode and per-channel gather
   //------------------------------------------------------------

   assign dbg_en  = ctl_q[cl_scrub_pkg::CTL_DBG_EN_BIT];
   assign dbg_sel = ctl_q[cl_scrub_pkg::CTL_DBG_SEL_LSB +: cl_scrub_pkg::CTL_DBG_SEL_W];

   for (genvar i = 0; i < cl_scrub_pkg::NUM_DDR; i++)
   begin : g_chan
      assign scrb[i].enable        = ctl_q[i];
      assign done_vec[i]           = scrb[i].done;
      assign dbg_states[4*i +: 4]  = {1'b0, scrb[i].state};
      assign chan_addr[i]          = scrb[i].addr;
   end

   // Selects past the last channel fall back to channel 0
   assign dbg_chan = (dbg_sel < cl_scrub_pkg::NUM_DDR) ?
                     dbg_sel[$clog2(cl_scrub_pkg::NUM_DDR)-1:0] : '0;
   assign dbg_addr = chan_addr[dbg_chan];

   //------------------------------------------------------------
   // Status and ID words
   //------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         status0 <= {dbg_states, 4'h0, 4'hf, done_vec, ready_q};
         id0     <= dbg_addr[31:0];
         id1     <= dbg_addr[63:32];
      end
      else
      begin
         status0 <= {cl_scrub_pkg::STATUS_SIGNATURE, 4'hf, done_vec, ready_q};
         id0     <= cl_scrub_pkg::CL_SH_ID0;
         id1     <= cl_scrub_pkg::CL_SH_ID1;
      end
      status1 <= cl_scrub_pkg::CL_VERSION;
   end

   //------------------------------------------------------------
   // Function-level reset answer
   //------------------------------------------------------------

   // Done toggles every cycle while the request stays asserted
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

/* verilog/ddr_scrubber.sv */
// Memory scrubber for one DDR channel.
// Walks the channel from address zero to SCRB_MAX_ADDR one burst at a time.
// Each burst is a level request held until the memory side pulses scrb_ack.

`timescale 1ns/1ps

module ddr_scrubber (
   input  logic                clk,
   input  logic                sync_rst_n,
   input  logic                ddr_ready,
   scrb_if.scrb                scrb,
   output logic                scrb_req,
   output cl_scrub_pkg::addr_t scrb_addr,
   input  logic                scrb_ack
);

   cl_scrub_pkg::scrb_state_t state_q;
   cl_scrub_pkg::addr_t       addr_q;
   logic                      burst_ack;
   logic                      last_burst;

   // Request only while running and the channel is up
   assign scrb_req  = (state_q == cl_scrub_pkg::SCRB_RUN) && ddr_ready;
   assign burst_ack = scrb_req && scrb_ack;

   // Current burst covers the final byte
   assign last_burst =
      (addr_q + cl_scrub_pkg::SCRB_BURST_BYTES) > cl_scrub_pkg::SCRB_MAX_ADDR;

   //------------------------------------------------------------
   // Scrub FSM
   //------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state_q <= cl_scrub_pkg::SCRB_IDLE;
         addr_q  <= '0;
      end
      else
      begin
         case (state_q)
            cl_scrub_pkg::SCRB_IDLE:
            begin
               addr_q <= '0;
               if (scrb.enable && ddr_ready)
               begin
                  state_q <= cl_scrub_pkg::SCRB_RUN;
               end
            end
            cl_scrub_pkg::SCRB_RUN:
            begin
               if (!scrb.enable)
               begin
                  state_q <= cl_scrub_pkg::SCRB_IDLE;
                  addr_q  <= '0;
               end
               else if (burst_ack)
               begin
                  // Last address stays visible for debug readout
                  if (last_burst)
                  begin
                     state_q <= cl_scrub_pkg::SCRB_DONE;
                  end
                  else
                  begin
                     addr_q <= addr_q + cl_scrub_pkg::SCRB_BURST_BYTES;
                  end
               end
            end
            cl_scrub_pkg::SCRB_DONE:
            begin
               if (!scrb.enable)
               begin
                  state_q <= cl_scrub_pkg::SCRB_IDLE;
                  addr_q  <= '0;
               end
            end
            default:
            begin
               state_q <= cl_scrub_pkg::SCRB_IDLE;
               addr_q  <= '0;
            end
         endcase
      end
   end

   assign scrb_addr  = addr_q;
   assign scrb.state = state_q;
   assign scrb.addr  = addr_q;
   assign scrb.done  = (state_q == cl_scrub_pkg::SCRB_DONE);

endmodule

/* verilog/lib_pipe.sv */
// Register pipeline of STAGES flops for any payload type.
// Used on the shell control word and on the DDR ready vector.
// All stages clear to zero on reset.

`timescale 1ns/1ps

module lib_pipe #(
   parameter type T      = logic,
   parameter int  STAGES = 1
) (
   input  logic clk,
   input  logic sync_rst_n,
   input  T     in_bus,
   output T     out_bus
);

   T stage_q [STAGES];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int s = 0; s < STAGES; s++)
         begin
            stage_q[s] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= in_bus;
         // Shift toward the output
         for (int s = 1; s < STAGES; s++)
         begin
            stage_q[s] <= stage_q[s-1];
         end
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule

/* verilog/scrb_if.sv */
// One channel's scrubber link between the register block and a scrubber.
// The register block owns the enable, the scrubber reports the rest.

`timescale 1ns/1ps

interface scrb_if;

   logic                      enable;
   cl_scrub_pkg::scrb_state_t state;
   cl_scrub_pkg::addr_t       addr;
   logic                      done;

   // Register block side
   modport ctl (
      output enable,
      input  state,
      input  addr,
      input  done
   );

   // Scrubber side
   modport scrb (
      input  enable,
      output state,
      output addr,
      output done
   );

endinterface
